//--- all.f
st_bus_pkg.sv
st_addr_decode.sv
st_bus_timer.sv
st_irq_ctrl.sv
st_glue.sv
tb_st_glue_asserts.sv
tb_st_glue.sv

//--- run.sh
#!/bin/sh
# build and run the st glue testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
	--top-module tb_st_glue -o sim_st_glue
out=$(./obj_dir/sim_st_glue)
echo "$out"
echo "$out" | grep -qF "** PASS **"

//--- st_addr_decode.sv
//==========================================================================
// st glue address decoder
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module st_addr_decode (
	input  wire                         clk_8,
	input  wire                         pll_locked,
	input  wire st_bus_pkg::cpu_bus_t   bus,
	input  wire st_bus_pkg::mem_size_e  mem_cfg,
	output st_bus_pkg::bus_dec_t        dec,
	output st_bus_pkg::io_sel_t         io_sel,
	output logic                        ram_we,
	output logic                        mem_oe,
	output logic [7:0]                  auto_vector
);

	logic [st_bus_pkg::addr_w-1:0] a;	// a[22:0] = byte a23..a1
	logic [15:0] io_off;	// byte offset inside ff page
	logic strobe;
	logic ram_cfg, ram_14m;
	logic tos256k, tos192k, cart;
	logic mem_hit, io_cyc, iack_cyc;
	logic mfp_iack, auto_iack;

	function automatic logic page_hit(input logic [15:0] off, input logic [15:0] base,
			input logic [15:0] mask);
		page_hit = (off & mask) == base;
	endfunction

	assign a      = bus.addr;
	assign io_off = {a[14:0], 1'b0};

	// data strobe, one clock behind uds/lds
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			strobe <= 1'b0;
		else
			strobe <= !bus.uds_n || !bus.lds_n;
	end

	// ram map, first 4mb always there
	assign ram_14m = (a[22:21] == 2'b00) || (a[22:21] == 2'b01) ||
			(a[22:21] == 2'b10) || (a[22:20] == 3'b110);
	assign ram_cfg = (a[22:21] == 2'b00) ||
			((mem_cfg == st_bus_pkg::mem_8m || mem_cfg == st_bus_pkg::mem_14m) &&
			(a[22:21] == 2'b01)) ||
			(mem_cfg == st_bus_pkg::mem_14m &&
			((a[22:21] == 2'b10) || (a[22:20] == 3'b110)));	// 8..14mb

	assign tos256k = (a[22:17] == 6'b111000);	// e00000-e3ffff
	assign tos192k = (a[22:16] == 7'b1111110) || (a[22:15] == 8'b11111110);
	assign cart    = (a[22:16] == 7'b1111101);	// fa0000-fbffff

	// rom and cartridge only answer reads
	assign mem_hit = ram_14m || (bus.rw && (tos256k || tos192k || cart));

	assign io_cyc   = strobe && (a[22:15] == 8'hff);
	assign iack_cyc = strobe && (a[22:3] == 20'hfffff);	// fffff0 and up

	assign mfp_iack  = iack_cyc && (a[2:0] == 3'd6);	// mfp on level 6
	assign auto_iack = iack_cyc && ((a[2:0] == 3'd4) || (a[2:0] == 3'd2));

	always_comb begin
		io_sel.mmu  = io_cyc && page_hit(io_off, st_bus_pkg::mmu_base, st_bus_pkg::mmu_mask);
		io_sel.vreg = io_cyc && page_hit(io_off, st_bus_pkg::vreg_base, st_bus_pkg::vreg_mask);
		io_sel.mfp  = io_cyc && page_hit(io_off, st_bus_pkg::mfp_base, st_bus_pkg::mfp_mask);
		io_sel.acia = io_cyc && page_hit(io_off, st_bus_pkg::acia_base, st_bus_pkg::acia_mask);
		io_sel.psg  = io_cyc && page_hit(io_off, st_bus_pkg::psg_base, st_bus_pkg::psg_mask);
		io_sel.dma  = io_cyc && page_hit(io_off, st_bus_pkg::dma_base, st_bus_pkg::dma_mask);
	end

	always_comb begin
		dec.strobe   = strobe;
		dec.mem_hit  = mem_hit;
		dec.io_ack   = (|io_sel) || mfp_iack || auto_iack;
		dec.iack_lvl = a[2:0];
		dec.iack     = iack_cyc;
	end

	assign ram_we = strobe && !bus.rw && ram_cfg;	// only ram that is fitted
	assign mem_oe = strobe && bus.rw && mem_hit;

	// vectors for the two autovector levels
	always_comb begin
		if (auto_iack && a[2:0] == 3'd4)
			auto_vector = st_bus_pkg::vec_vbi;
		else if (auto_iack && a[2:0] == 3'd2)
			auto_vector = st_bus_pkg::vec_hbi;
		else
			auto_vector = 8'h00;
	end

endmodule

`default_nettype wire

//--- st_bus_pkg.sv
//==========================================================================
// atari st glue, shared bus types
//==========================================================================
`default_nettype none

package st_bus_pkg;

	localparam int addr_w = 23;	// word address, cpu a23..a1

	// cpu bus as seen by the glue
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic              uds_n;
		logic              lds_n;
		logic              rw;	// high = read
	} cpu_bus_t;

	// st ram size code
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_e;

	// peripheral chip selects in the i/o page
	typedef struct packed {
		logic mmu;
		logic vreg;
		logic mfp;
		logic acia;
		logic psg;
		logic dma;
	} io_sel_t;

	// decoder results for timer and irq unit
	typedef struct packed {
		logic       strobe;	// registered uds/lds
		logic       mem_hit;	// full 14mb map, rom/cart on read
		logic       io_ack;	// selects + iack cycles
		logic [2:0] iack_lvl;
		logic       iack;	// strobed iack cycle
	} bus_dec_t;

	// active low ipl, ipl[0] always high on the st
	typedef enum logic [2:0] {
		ipl_none = 3'b111,
		ipl_hbi  = 3'b101,
		ipl_vbi  = 3'b011,
		ipl_mfp  = 3'b001
	} ipl_e;

	localparam int timeout_max = 31;	// unacked strobed cycles before berr
	localparam int berr_cnt_w  = 4;

	localparam logic [7:0] vec_vbi = 8'h1c;	// level 4 autovector
	localparam logic [7:0] vec_hbi = 8'h1a;	// level 2 autovector

	// i/o page bases, low 16 bits of the byte address
	localparam logic [15:0] mmu_base  = 16'h8000;
	localparam logic [15:0] vreg_base = 16'h8200;
	localparam logic [15:0] psg_base  = 16'h8800;
	localparam logic [15:0] dma_base  = 16'h8600;
	localparam logic [15:0] mfp_base  = 16'hfa00;
	localparam logic [15:0] acia_base = 16'hfc00;

	// decode masks for each page
	localparam logic [15:0] mmu_mask  = 16'hfffe;	// 8000-8001
	localparam logic [15:0] vreg_mask = 16'hff80;	// 8200-827f
	localparam logic [15:0] psg_mask  = 16'hff00;	// 8800-88ff
	localparam logic [15:0] dma_mask  = 16'hfff0;	// 8600-860f
	localparam logic [15:0] mfp_mask  = 16'hffc0;	// fa00-fa3f
	localparam logic [15:0] acia_mask = 16'hff00;	// fc00-fcff

endpackage

`default_nettype wire

//--- st_bus_timer.sv
//==========================================================================
// dtack and bus error timeout
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module st_bus_timer (
	input  wire                        clk_8,
	input  wire                        pll_locked,
	input  wire st_bus_pkg::bus_dec_t  dec,
	input  wire                        br,	// other master wants the bus
	input  wire                        cpu_ena,	// fast ram cycle
	input  wire                        clr_berr,
	output logic                       dtack_n,
	output logic                       berr,
	output logic [st_bus_pkg::berr_cnt_w-1:0] berr_count
);

	logic [4:0] tmo_cnt;
	logic berr_d;	// for rise detect
	logic [st_bus_pkg::berr_cnt_w-1:0] berr_total;
	logic [st_bus_pkg::berr_cnt_w-1:0] berr_next;

	// bus request just halts the cpu by holding dtack off
	assign dtack_n = !(dec.strobe && (dec.mem_hit || dec.io_ack) && !br);

	assign berr = (tmo_cnt == 5'(st_bus_pkg::timeout_max));

	// count strobed cycles that nobody answers
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			tmo_cnt <= 5'd0;
		end else if (!berr) begin
			if (!dtack_n || br || cpu_ena || !dec.strobe)
				tmo_cnt <= 5'd0;
			else
				tmo_cnt <= tmo_cnt + 5'd1;
		end else if (clr_berr) begin
			tmo_cnt <= 5'd0;	// cpu took the exception
		end
	end

	assign berr_next = berr_total + {{(st_bus_pkg::berr_cnt_w-1){1'b0}}, 1'b1};

	// running total, shown for one cycle per error
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			berr_d     <= 1'b0;
			berr_total <= '0;
			berr_count <= '0;
		end else begin
			berr_d     <= berr;
			berr_count <= '0;
			if (berr && !berr_d) begin
				berr_total <= berr_next;
				berr_count <= berr_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- st_glue.sv
//==========================================================================
// atari st bus glue, top level
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module st_glue (
	input  wire                         clk_8,
	input  wire                         pll_locked,
	input  wire st_bus_pkg::cpu_bus_t   bus,
	input  wire                         br,
	input  wire                         cpu_ena,
	input  wire                         clr_berr,
	input  wire st_bus_pkg::mem_size_e  mem_cfg,
	input  wire                         vs,
	input  wire                         hs,
	input  wire                         mfp_irq,
	output logic                        dtack_n,
	output logic                        berr,
	output logic [st_bus_pkg::berr_cnt_w-1:0] berr_count,
	output st_bus_pkg::ipl_e            ipl,
	output logic [7:0]                  auto_vector,
	output st_bus_pkg::io_sel_t         io_sel,
	output logic                        ram_we,
	output logic                        mem_oe
);

	st_bus_pkg::bus_dec_t dec;	// decoder to timer and irq

	st_addr_decode u_decode (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.bus         (bus),
		.mem_cfg     (mem_cfg),
		.dec         (dec),
		.io_sel      (io_sel),
		.ram_we      (ram_we),
		.mem_oe      (mem_oe),
		.auto_vector (auto_vector)
	);

	st_bus_timer u_timer (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.dec        (dec),
		.br         (br),
		.cpu_ena    (cpu_ena),
		.clr_berr   (clr_berr),
		.dtack_n    (dtack_n),
		.berr       (berr),
		.berr_count (berr_count)
	);

	st_irq_ctrl u_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.dec        (dec),
		.vs         (vs),
		.hs         (hs),
		.mfp_irq    (mfp_irq),
		.ipl        (ipl)
	);

endmodule

`default_nettype wire

//--- st_irq_ctrl.sv
//==========================================================================
// vbi/hbi latches and ipl encoder
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module st_irq_ctrl (
	input  wire                        clk_8,
	input  wire                        pll_locked,
	input  wire st_bus_pkg::bus_dec_t  dec,
	input  wire                        vs,	// vsync from video
	input  wire                        hs,	// hsync from video
	input  wire                        mfp_irq,
	output st_bus_pkg::ipl_e           ipl
);

	// bit 0 carries vs/vbi, bit 1 hs/hbi
	logic [1:0] sync1;
	logic [1:0] sync2;
	logic [1:0] sync_d;	// last synced value
	logic [1:0] rise;
	logic [1:0] ack;
	logic [1:0] pend;	// {hbi, vbi}

	// two stage sync, then edge flop
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync1  <= 2'b00;
			sync2  <= 2'b00;
			sync_d <= 2'b00;
		end else begin
			sync1  <= {hs, vs};
			sync2  <= sync1;
			sync_d <= sync2;
		end
	end

	assign rise = sync2 & ~sync_d;	// one cycle event

	// iack cycles for level 4 (vbi) and 2 (hbi)
	assign ack[0] = dec.iack && (dec.iack_lvl == 3'd4);
	assign ack[1] = dec.iack && (dec.iack_lvl == 3'd2);

	// ack wins over a new edge in the same cycle
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			pend <= 2'b00;
		else
			pend <= (pend | rise) & ~ack;
	end

	// mfp level 6 highest, then vbi, then hbi
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			ipl <= st_bus_pkg::ipl_none;
		else if (mfp_irq)
			ipl <= st_bus_pkg::ipl_mfp;
		else if (pend[0])
			ipl <= st_bus_pkg::ipl_vbi;
		else if (pend[1])
			ipl <= st_bus_pkg::ipl_hbi;
		else
			ipl <= st_bus_pkg::ipl_none;
	end

endmodule

`default_nettype wire

//--- tb_st_glue.sv
//==========================================================================
// st glue testbench
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_st_glue;

	// expected decoder response for one strobed cycle
	typedef struct packed {
		st_bus_pkg::io_sel_t sel;
		logic                ram_we;
		logic                mem_oe;
		logic                mapped;	// dtack without br
		logic [7:0]          vec;
	} exp_t;

	logic clk_8, pll_locked, br, cpu_ena, clr_berr, vs, hs, mfp_irq;
	st_bus_pkg::cpu_bus_t bus;
	st_bus_pkg::mem_size_e mem_cfg;
	logic dtack_n, berr, ram_we, mem_oe;
	logic [3:0] berr_count;
	logic [7:0] auto_vector;
	st_bus_pkg::ipl_e ipl;
	st_bus_pkg::io_sel_t io_sel;
	logic [15:0] lfsr;
	logic pend_v, pend_h;	// model vbi/hbi latches
	logic [3:0] berr_total;	// model error total
	int errs, tmos;

	st_glue dut0 (.*);

	function automatic logic lfsr_bit();	// galois, taps 16,14,13,11
		lfsr_bit = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
	endfunction

	function automatic logic [23:0] rand_bits(input int n);
		rand_bits = '0;
		for (int i = 0; i < n; i++)
			rand_bits = {rand_bits[22:0], lfsr_bit()};
	endfunction

	// byte address, biased towards rom, cart, i/o pages and iack
	function automatic logic [23:0] rand_addr();
		logic [23:0] r;
		logic [63:0] pages;
		pages = 64'h80_82_86_88_fa_fc_92_ff;
		r = rand_bits(3);
		case (r[2:0])
			3'd0, 3'd1: rand_addr = rand_bits(24);
			3'd2: rand_addr = 24'he00000 | rand_bits(18);	// tos 256k
			3'd3: rand_addr = 24'hfa0000 | rand_bits(17);	// cartridge
			3'd4: rand_addr = 24'hfc0000 + (rand_bits(18) % 24'h030000);
			3'd7: rand_addr = 24'hfffff0 | rand_bits(4);	// iack
			default: begin
				r = rand_bits(12);
				rand_addr = {8'hff, pages[8*r[2:0] +: 8], r[11:4]};
				if (r[3])
					rand_addr[7:4] = 4'h0;	// low offsets hit mmu and dma
			end
		endcase
		rand_addr[0] = 1'b0;
	endfunction

	function automatic exp_t model(input logic [23:0] ba, input logic rw,
			input st_bus_pkg::mem_size_e cfg);
		exp_t e;
		logic [23:0] ram_top;
		logic hit, iack;
		logic [2:0] lvl;
		ram_top = (cfg == st_bus_pkg::mem_14m) ? 24'he00000 :
				(cfg == st_bus_pkg::mem_8m) ? 24'h800000 : 24'h400000;
		iack = ba >= 24'hfffff0;
		lvl = ba[3:1];
		hit = (ba < 24'he00000) || (rw && ((ba >= 24'he00000 && ba <= 24'he3ffff) ||
				(ba >= 24'hfa0000 && ba <= 24'hfeffff)));	// rom and cart on read
		e.sel.mmu  = ba >= 24'hff8000 && ba <= 24'hff8001;
		e.sel.vreg = ba >= 24'hff8200 && ba <= 24'hff827f;
		e.sel.mfp  = ba >= 24'hfffa00 && ba <= 24'hfffa3f;
		e.sel.acia = ba >= 24'hfffc00 && ba <= 24'hfffcff;
		e.sel.psg  = ba >= 24'hff8800 && ba <= 24'hff88ff;
		e.sel.dma  = ba >= 24'hff8600 && ba <= 24'hff860f;
		e.ram_we = !rw && (ba < ram_top);
		e.mem_oe = rw && hit;
		e.mapped = hit || (|e.sel) || (iack && (lvl == 3'd6 || lvl == 3'd4 || lvl == 3'd2));
		e.vec = !iack ? 8'h00 : (lvl == 3'd4) ? 8'h1c : (lvl == 3'd2) ? 8'h1a : 8'h00;
		model = e;
	endfunction

	function automatic st_bus_pkg::ipl_e model_ipl();
		if (mfp_irq)
			model_ipl = st_bus_pkg::ipl_mfp;
		else if (pend_v)
			model_ipl = st_bus_pkg::ipl_vbi;
		else if (pend_h)
			model_ipl = st_bus_pkg::ipl_hbi;
		else
			model_ipl = st_bus_pkg::ipl_none;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			errs++;
		end
	endtask

	// one strobed cycle, outputs checked a clock after the strobe
	task automatic bus_cycle(input logic [23:0] ba, input logic rw, input logic [1:0] ds_n);
		exp_t e;
		@(negedge clk_8);
		bus = '{addr: ba[23:1], uds_n: ds_n[1], lds_n: ds_n[0], rw: rw};
		@(negedge clk_8);
		e = model(ba, rw, mem_cfg);
		check_val("io_sel", 32'(io_sel), 32'(e.sel));
		check_val("ram_we", 32'(ram_we), 32'(e.ram_we));
		check_val("mem_oe", 32'(mem_oe), 32'(e.mem_oe));
		check_val("dtack_n", 32'(dtack_n), 32'(!(e.mapped && !br)));
		check_val("auto_vector", 32'(auto_vector), 32'(e.vec));
		bus.uds_n = 1'b1;
		bus.lds_n = 1'b1;
	endtask

	task automatic wait_ipl(input st_bus_pkg::ipl_e want);
		int n;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (ipl != want && n < 8);
		if (ipl != want) begin
			$display("timeout: ipl stayed at %h while waiting for %h", ipl, want);
			tmos++;
		end
	endtask

	task automatic wait_berr(input logic level, input int limit);
		int n;
		n = 0;
		while (berr != level && n < limit) begin
			@(negedge clk_8);
			n++;
		end
		if (berr != level) begin
			$display("timeout: berr did not go to %0d within %0d cycles", level, limit);
			tmos++;
		end
	endtask

	initial begin
		clk_8 = 1'b0;
		forever #2 clk_8 = ~clk_8;	// 4 ns period
	end

	initial begin
		logic [23:0] r;
		pll_locked = 1'b0;
		br = 1'b0;
		cpu_ena = 1'b0;
		clr_berr = 1'b0;
		vs = 1'b0;
		hs = 1'b0;
		mfp_irq = 1'b0;
		bus = '{addr: '0, uds_n: 1'b1, lds_n: 1'b1, rw: 1'b1};
		mem_cfg = st_bus_pkg::mem_512k;
		lfsr = 16'd50310;
		pend_v = 1'b0;
		pend_h = 1'b0;
		berr_total = 4'd0;
		errs = 0;
		tmos = 0;
		repeat (3) @(posedge clk_8);
		@(negedge clk_8);
		pll_locked = 1'b1;

		repeat (300) begin	// random map, selects and dtack
			r = rand_bits(8);
			mem_cfg = st_bus_pkg::mem_size_e'((r[2:0] > 3'd5) ? r[2:0] - 3'd3 : r[2:0]);
			br = (r[4:3] == 2'b00);
			bus_cycle(rand_addr(), r[5], (r[7:6] == 2'b11) ? 2'b10 : r[7:6]);
		end

		// held strobe on ram, br keeps dtack off and the timer at zero
		br = 1'b1;
		bus = '{addr: 23'h000100, uds_n: 1'b0, lds_n: 1'b0, rw: 1'b1};
		repeat (40) begin
			@(negedge clk_8);
			check_val("dtack_n", 32'(dtack_n), 32'd1);
			check_val("berr", 32'(berr), 32'd0);
		end
		br = 1'b0;
		cpu_ena = 1'b1;	// fast ram cycles hold the timer too
		bus.addr = 23'h7fc900;	// ff9200, nobody answers
		repeat (40) begin
			@(negedge clk_8);
			check_val("dtack_n", 32'(dtack_n), 32'd1);
			check_val("berr", 32'(berr), 32'd0);
		end
		cpu_ena = 1'b0;
		repeat (3) begin
			wait_berr(1'b1, 40);
			berr_total = berr_total + 4'd1;
			@(negedge clk_8);
			check_val("berr_count", 32'(berr_count), 32'(berr_total));
			clr_berr = 1'b1;
			wait_berr(1'b0, 4);
			clr_berr = 1'b0;
		end
		bus.uds_n = 1'b1;
		bus.lds_n = 1'b1;

		repeat (40) begin	// random irq lines, latches set on rising edges
			r = rand_bits(3);
			pend_v = pend_v | (r[0] && !vs);
			pend_h = pend_h | (r[1] && !hs);
			vs = r[0];
			hs = r[1];
			mfp_irq = r[2];
			wait_ipl(model_ipl());
		end

		repeat (2) begin	// autovector iack clears its own latch only
			vs = 1'b0;
			hs = 1'b0;
			mfp_irq = 1'b0;
			repeat (4) @(negedge clk_8);	// sync and edge flops settle
			vs = 1'b1;
			hs = 1'b1;
			pend_v = 1'b1;
			pend_h = 1'b1;
			repeat (4) @(negedge clk_8);
			wait_ipl(st_bus_pkg::ipl_vbi);
			bus_cycle(24'hfffff8, 1'b1, 2'b00);	// level 4
			pend_v = 1'b0;
			wait_ipl(st_bus_pkg::ipl_hbi);
			bus_cycle(24'hfffff4, 1'b1, 2'b00);	// level 2
			pend_h = 1'b0;
			wait_ipl(st_bus_pkg::ipl_none);
		end

		$display("errors: %0d value mismatches, %0d timeouts", errs, tmos);
		if (errs == 0 && tmos == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_st_glue_asserts.sv
//==========================================================================
// st glue bus assertions
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_st_glue_asserts (
	input wire                    clk_8,
	input wire                    pll_locked,
	input wire                    br,
	input wire                    dtack_n,
	input wire [3:0]              berr_count,
	input wire st_bus_pkg::ipl_e  ipl
);

	// error total shows for a single cycle
	count_pulse: assert property (@(posedge clk_8) disable iff (!pll_locked)
		(berr_count != 4'd0) |=> (berr_count == 4'd0))
		else $error("berr_count stayed nonzero for more than one cycle");

	br_hold: assert property (@(posedge clk_8) disable iff (!pll_locked)
		br |-> dtack_n)	// bus request keeps the cpu waiting
		else $error("dtack_n went low while br was high");

	// no interrupt level straight out of reset
	ipl_reset: assert property (@(posedge clk_8)
		$rose(pll_locked) |=> (ipl == st_bus_pkg::ipl_none))
		else $error("ipl not idle in the cycle after reset");

endmodule

bind st_glue tb_st_glue_asserts u_asserts (
	.clk_8      (clk_8),
	.pll_locked (pll_locked),
	.br         (br),
	.dtack_n    (dtack_n),
	.berr_count (berr_count),
	.ipl        (ipl)
);

`default_nettype wire
